// ==== design/sga_apple_gen.sv ====
// ----------------------------------------------------------------------
// apple source: 6-bit LFSR search with out-of-grid rejection
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sga_apple_gen (
    input  logic          clock,
    input  logic          rst,
    input  logic          restart,
    input  logic          apple_req,
    output sga_pkg::pos_t apple,
    output logic          apple_ready
);

    sga_pkg::pos_t lfsr;
    sga_pkg::pos_t lfsr_next;
    logic          searching;
    logic          legal;

    // shift left, feedback from bits 5 and 4, period 63
    assign lfsr_next = {lfsr[sga_pkg::POS_W-2:0],
                        lfsr[sga_pkg::POS_W-1] ^ lfsr[sga_pkg::POS_W-2]};

    // only values inside the grid become apples
    assign legal = (lfsr_next < sga_pkg::pos_t'(sga_pkg::CELLS));

    assign apple_ready = !searching;

    // search runs from reset, restart or a request
    always_ff @(posedge clock) begin
        if (rst || restart) begin
            lfsr      <= sga_pkg::LFSR_SEED;
            searching <= 1'b1;
        end else if (apple_req) begin
            searching <= 1'b1;
        end else if (searching) begin
            // one LFSR step per search cycle
            lfsr <= lfsr_next;
            if (legal) begin
                searching <= 1'b0;
            end
        end
    end

    // apple position register, loaded when the search hits
    always_ff @(posedge clock) begin
        if (searching && legal && !apple_req) begin
            apple <= lfsr_next;
        end
    end

endmodule

// ==== design/sga_body_if.sv ====
// ----------------------------------------------------------------------
// body memory bus: read port, length, collision status, move commands
// ----------------------------------------------------------------------
`timescale 1ns/1ps

interface sga_body_if;

    // render read port, combinational data
    sga_pkg::len_t rd_index;
    sga_pkg::pos_t rd_pos;

    // status from the body memory
    sga_pkg::len_t length;
    sga_pkg::pos_t next_head;
    logic          wall_hit;
    logic          self_hit;

    // commands from the controller
    logic          shift;
    logic          grow;
    logic          clear;
    sga_pkg::dir_t dir;

    modport body (
        input  rd_index, shift, grow, clear, dir,
        output rd_pos, length, next_head, wall_hit, self_hit
    );

    modport ctrl (
        input  length, next_head, wall_hit, self_hit,
        output shift, grow, clear, dir
    );

    modport rend (
        input  rd_pos, length,
        output rd_index
    );

endinterface

// ==== design/sga_body_mem.sv ====
// ----------------------------------------------------------------------
// snake segment store, next head, wall and self collision, length
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sga_body_mem (
    input  logic     clock,
    input  logic     rst,
    input  logic     restart,
    sga_body_if.body body
);

    // shift array, head at index 0
    sga_pkg::pos_t seg [sga_pkg::MAX_LEN];
    sga_pkg::len_t length_q;
    sga_pkg::len_t tail_idx;
    sga_pkg::pos_t head_row;
    sga_pkg::pos_t head_col;
    logic [sga_pkg::MAX_LEN-1:0] hit_vec;

    assign head_row = sga_pkg::pos_t'(seg[0] / sga_pkg::GRID_W);
    assign head_col = sga_pkg::pos_t'(seg[0] % sga_pkg::GRID_W);
    assign tail_idx = length_q - sga_pkg::len_t'(1);

    // next head and edge check from the latched direction
    always_comb begin
        case (body.dir)
            sga_pkg::dir_up: begin
                body.next_head = seg[0] - sga_pkg::pos_t'(sga_pkg::GRID_W);
                body.wall_hit  = (head_row == '0);
            end
            sga_pkg::dir_down: begin
                body.next_head = seg[0] + sga_pkg::pos_t'(sga_pkg::GRID_W);
                body.wall_hit  = (head_row == sga_pkg::pos_t'(sga_pkg::GRID_W - 1));
            end
            sga_pkg::dir_left: begin
                body.next_head = seg[0] - sga_pkg::pos_t'(1);
                body.wall_hit  = (head_col == '0);
            end
            default: begin
                body.next_head = seg[0] + sga_pkg::pos_t'(1);
                body.wall_hit  = (head_col == sga_pkg::pos_t'(sga_pkg::GRID_W - 1));
            end
        endcase
    end

    // one comparator per slot, only live segments count
    // tail moves away on a plain step so it is skipped then
    always_comb begin
        for (int i = 0; i < sga_pkg::MAX_LEN; i++) begin
            hit_vec[i] = (seg[i] == body.next_head)
                && (sga_pkg::len_t'(i) < length_q)
                && !((sga_pkg::len_t'(i) == tail_idx) && !body.grow);
        end
    end

    assign body.self_hit = |hit_vec;

    // render read, index past the array reads as zero
    assign body.rd_pos = (body.rd_index < sga_pkg::len_t'(sga_pkg::MAX_LEN))
        ? seg[body.rd_index] : '0;

    assign body.length = length_q;

    // clear puts the head on the start cell for a new game
    always_ff @(posedge clock) begin
        if (body.clear) begin
            seg[0] <= sga_pkg::START_POS;
        end else if (body.shift) begin
            seg[0] <= body.next_head;
            for (int i = 1; i < sga_pkg::MAX_LEN; i++) begin
                seg[i] <= seg[i-1];
            end
        end
    end

    // length counter, grow keeps the old tail slot alive
    always_ff @(posedge clock) begin
        if (rst || restart) begin
            length_q <= sga_pkg::len_t'(1);
        end else if (body.shift && body.grow) begin
            length_q <= length_q + sga_pkg::len_t'(1);
        end
    end

endmodule

// ==== design/sga_control.sv ====
// ----------------------------------------------------------------------
// game controller FSM, direction latch and apple score counter
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sga_control (
    input  logic                clock,
    input  logic                rst,
    input  logic                restart,
    input  logic                step,
    input  logic [3:0]          buttons,
    sga_body_if.ctrl            body,
    input  sga_pkg::pos_t       apple,
    input  logic                apple_ready,
    input  logic                render_finish,
    output logic                apple_req,
    output logic                render_start,
    output logic                frame_valid,
    output logic                busy,
    output logic                game_over,
    output logic [7:0]          score
);

    sga_pkg::state_t state;
    sga_pkg::dir_t   dir_q;
    sga_pkg::dir_t   btn_dir;
    logic            btn_valid;
    logic            btn_rev;
    // first frame of a game still has to be drawn
    logic            fresh;
    // render_finish seen while the apple search was still running
    logic            rend_done;
    logic            in_move;
    logic            stepping;
    logic            hit;
    logic            eat;
    logic            can_grow;

    // one-hot button decode, bit 0 up .. bit 3 right
    always_comb begin
        btn_valid = 1'b1;
        btn_dir   = dir_q;
        case (buttons)
            4'b0001: btn_dir = sga_pkg::dir_up;
            4'b0010: btn_dir = sga_pkg::dir_down;
            4'b0100: btn_dir = sga_pkg::dir_left;
            4'b1000: btn_dir = sga_pkg::dir_right;
            default: btn_valid = 1'b0;
        endcase
    end

    // reversal: same axis bit, other sign bit
    assign btn_rev = (btn_dir[1] == dir_q[1]) && (btn_dir[0] != dir_q[0]);

    assign in_move  = (state == sga_pkg::st_move);
    // a real move, not the draw of a new game
    assign stepping = in_move && !fresh;
    assign hit      = body.wall_hit || body.self_hit;
    assign eat      = (body.next_head == apple);
    assign can_grow = (body.length < sga_pkg::len_t'(sga_pkg::MAX_LEN));

    // move commands, all decided in the single st_move cycle
    assign body.dir   = dir_q;
    assign body.clear = in_move && fresh;
    assign body.shift = stepping && !hit;
    // grow is valid even on a hit so the tail rule sees it, shift gates it
    assign body.grow  = stepping && eat && can_grow;
    assign apple_req  = stepping && !hit && eat;
    assign render_start = in_move && (fresh || !hit);

    assign busy      = in_move || (state == sga_pkg::st_render);
    assign game_over = (state == sga_pkg::st_over);

    always_ff @(posedge clock) begin
        if (rst || restart) begin
            state       <= sga_pkg::st_idle;
            dir_q       <= sga_pkg::dir_right;
            score       <= 8'd0;
            fresh       <= 1'b1;
            rend_done   <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            case (state)
                sga_pkg::st_idle: begin
                    if (btn_valid && !btn_rev) begin
                        dir_q <= btn_dir;
                    end
                    // step only accepted with an apple on the board
                    if (apple_ready && (fresh || step)) begin
                        state <= sga_pkg::st_move;
                    end
                end
                sga_pkg::st_move: begin
                    fresh     <= 1'b0;
                    rend_done <= 1'b0;
                    if (stepping && hit) begin
                        state <= sga_pkg::st_over;
                    end else begin
                        if (apple_req) begin
                            score <= score + 8'd1;
                        end
                        state <= sga_pkg::st_render;
                    end
                end
                sga_pkg::st_render: begin
                    if (render_finish) begin
                        rend_done <= 1'b1;
                    end
                    // frame done only once both render and apple are in
                    if ((rend_done || render_finish) && apple_ready) begin
                        frame_valid <= 1'b1;
                        state       <= sga_pkg::st_idle;
                    end
                end
                // held until restart
                sga_pkg::st_over: state <= sga_pkg::st_over;
                default: state <= sga_pkg::st_idle;
            endcase
        end
    end

endmodule

// ==== design/sga_pkg.sv ====
// ----------------------------------------------------------------------
// shared constants, vector types and enums of the snake game engine
// ----------------------------------------------------------------------

package sga_pkg;

    // grid geometry, cell index is row * GRID_W + col
    localparam int GRID_W = 6;
    localparam int CELLS  = GRID_W * GRID_W;
    localparam int POS_W  = 6;

    // snake length limits, a segment index uses the same width
    localparam int MAX_LEN = 15;
    localparam int LEN_W   = 4;

    typedef logic [POS_W-1:0] pos_t;
    typedef logic [LEN_W-1:0] len_t;
    typedef logic [CELLS-1:0] frame_t;

    // head cell on a new game, row 2 col 2
    localparam pos_t START_POS = pos_t'(2 * GRID_W + 2);

    // apple LFSR value after reset or restart
    localparam pos_t LFSR_SEED = pos_t'(1);

    // opposite directions differ only in bit 0
    typedef enum logic [1:0] {
        dir_up    = 2'b00,
        dir_down  = 2'b01,
        dir_left  = 2'b10,
        dir_right = 2'b11
    } dir_t;

    // controller states
    typedef enum logic [1:0] {
        st_idle,
        st_move,
        st_render,
        st_over
    } state_t;

endpackage

// ==== design/sga_renderer.sv ====
// ----------------------------------------------------------------------
// frame builder: render counter, end compare and LED frame register
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sga_renderer (
    input  logic            clock,
    input  logic            rst,
    input  logic            render_start,
    input  sga_pkg::pos_t   apple,
    sga_body_if.rend        body,
    output sga_pkg::frame_t leds,
    output logic            render_finish
);

    sga_pkg::len_t   cnt;
    logic            active;
    logic            at_end;
    sga_pkg::frame_t pos_bit;
    sga_pkg::frame_t apple_bit;
    // frame under construction
    sga_pkg::frame_t work;
    // last finished body frame
    sga_pkg::frame_t frame_q;

    // walk the body from the head
    assign body.rd_index = cnt;

    // end compare, counter reached the snake length
    assign at_end = active && (cnt == body.length);

    assign pos_bit   = sga_pkg::frame_t'(1) << body.rd_pos;
    assign apple_bit = sga_pkg::frame_t'(1) << apple;

    // apple lit straight from its register
    // it only moves during a busy step, before frame_valid
    assign leds = frame_q | apple_bit;

    // counter control, finish pulse is one cycle after the compare
    always_ff @(posedge clock) begin
        if (rst) begin
            active        <= 1'b0;
            cnt           <= '0;
            render_finish <= 1'b0;
            frame_q       <= '0;
        end else begin
            render_finish <= at_end;
            if (render_start) begin
                active <= 1'b1;
                cnt    <= '0;
            end else if (at_end) begin
                active  <= 1'b0;
                frame_q <= work;
            end else if (active) begin
                cnt <= cnt + sga_pkg::len_t'(1);
            end
        end
    end

    // OR one segment per cycle into the working frame
    always_ff @(posedge clock) begin
        if (render_start) begin
            work <= '0;
        end else if (active && !at_end) begin
            work <= work | pos_bit;
        end
    end

endmodule

// ==== design/sga_top.sv ====
// ----------------------------------------------------------------------
// snake game top: controller, body memory, apple source, renderer
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sga_top (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      restart,
    input  logic                      step,
    input  logic [3:0]                buttons,
    output logic [sga_pkg::CELLS-1:0] leds,
    output logic                      frame_valid,
    output logic                      busy,
    output logic                      game_over,
    output logic [sga_pkg::LEN_W-1:0] length,
    output logic [7:0]                score
);

    sga_pkg::pos_t apple;
    logic          apple_ready;
    logic          apple_req;
    logic          render_start;
    logic          render_finish;

    // body memory bus shared by controller, store and renderer
    sga_body_if body_bus ();

    assign length = body_bus.length;

    sga_control u_control (
        .clock         (clock),
        .rst           (rst),
        .restart       (restart),
        .step          (step),
        .buttons       (buttons),
        .body          (body_bus.ctrl),
        .apple         (apple),
        .apple_ready   (apple_ready),
        .render_finish (render_finish),
        .apple_req     (apple_req),
        .render_start  (render_start),
        .frame_valid   (frame_valid),
        .busy          (busy),
        .game_over     (game_over),
        .score         (score)
    );

    sga_body_mem u_body_mem (
        .clock   (clock),
        .rst     (rst),
        .restart (restart),
        .body    (body_bus.body)
    );

    sga_apple_gen u_apple_gen (
        .clock       (clock),
        .rst         (rst),
        .restart     (restart),
        .apple_req   (apple_req),
        .apple       (apple),
        .apple_ready (apple_ready)
    );

    sga_renderer u_renderer (
        .clock         (clock),
        .rst           (rst),
        .render_start  (render_start),
        .apple         (apple),
        .body          (body_bus.rend),
        .leds          (leds),
        .render_finish (render_finish)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# build the snake game testbench with Verilator, run it, judge the log
verilator --binary --timing --assert -Wno-fatal --top-module sga_tb \
    -f vlog.f -o sga_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/sga_sim > sim.log 2>&1
cat sim.log
grep -q "^>>> PASS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/sga_props.sv ====
// ----------------------------------------------------------------------
// controller assertions for frame after busy, sticky game over
// and the render start transition
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sga_props (
    input logic            clock,
    input logic            rst,
    input logic            restart,
    input logic            frame_valid,
    input logic            busy,
    input logic            game_over,
    input logic            render_start,
    input sga_pkg::state_t state
);

    // a frame always closes a busy step
    frame_after_busy: assert property (
        @(posedge clock) disable iff (rst || restart)
        frame_valid |-> $past(busy)
    ) else $error("frame_valid without busy in the cycle before");

    // game over holds until restart
    over_held: assert property (
        @(posedge clock) disable iff (rst)
        (game_over && !restart) |=> game_over
    ) else $error("game_over dropped without restart");

    // render start only leaving st_move for st_render
    start_then_render: assert property (
        @(posedge clock) disable iff (rst || restart)
        render_start |=> (state == sga_pkg::st_render)
    ) else $error("render_start not followed by st_render");

endmodule

// attach to every controller instance
bind sga_control sga_props props0 (
    .clock        (clock),
    .rst          (rst),
    .restart      (restart),
    .frame_valid  (frame_valid),
    .busy         (busy),
    .game_over    (game_over),
    .render_start (render_start),
    .state        (state)
);

// ==== tests/sga_tb.sv ====
// ----------------------------------------------------------------------
// snake game testbench: clock, reset, seeded random steering,
// reference game model, frame checks, restart and watchdog
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sga_tb;

    logic                      clock;
    logic                      rst;
    logic                      restart;
    logic                      step;
    logic [3:0]                buttons;
    logic [sga_pkg::CELLS-1:0] leds;
    logic                      frame_valid;
    logic                      busy;
    logic                      game_over;
    logic [sga_pkg::LEN_W-1:0] length;
    logic [7:0]                score;

    // reference model, head at index 0
    sga_pkg::pos_t m_seg [sga_pkg::MAX_LEN];
    int            m_len;
    sga_pkg::dir_t m_dir;
    int            m_score;
    sga_pkg::pos_t m_lfsr;
    sga_pkg::pos_t m_apple;
    logic          m_over;

    integer        seed;
    int            mismatches;
    int            failures;
    int            steps;
    int            eats;
    int            overs;

    sga_top dut0 (
        .clock       (clock),
        .rst         (rst),
        .restart     (restart),
        .step        (step),
        .buttons     (buttons),
        .leds        (leds),
        .frame_valid (frame_valid),
        .busy        (busy),
        .game_over   (game_over),
        .length      (length),
        .score       (score)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // 300 steps at up to 100 cycles of 20 ns each
    initial begin
        #(300 * 100 * 20);
        $display("Error: watchdog expired at %0t before all steps were played", $time);
        $display(">>> FAIL");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        mismatches++;
        $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp_val, act_val);
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // shift left, new bit 0 = bit 5 xor bit 4
    function automatic sga_pkg::pos_t lfsr_advance(input sga_pkg::pos_t x);
        return {x[4:0], x[5] ^ x[4]};
    endfunction

    // next LFSR value inside the grid becomes the apple
    task automatic next_apple();
        m_lfsr = lfsr_advance(m_lfsr);
        while (m_lfsr >= sga_pkg::CELLS) begin
            m_lfsr = lfsr_advance(m_lfsr);
        end
        m_apple = m_lfsr;
    endtask

    task automatic model_new_game();
        m_len    = 1;
        m_seg[0] = sga_pkg::START_POS;
        m_dir    = sga_pkg::dir_right;
        m_score  = 0;
        m_over   = 1'b0;
        m_lfsr   = sga_pkg::LFSR_SEED;
        next_apple();
    endtask

    function automatic sga_pkg::frame_t model_frame();
        sga_pkg::frame_t f;
        f = '0;
        for (int i = 0; i < m_len; i++) begin
            f[m_seg[i]] = 1'b1;
        end
        f[m_apple] = 1'b1;
        return f;
    endfunction

    // one-hot press that is not the reverse turns the snake
    task automatic model_buttons(input logic [3:0] b);
        sga_pkg::dir_t d;
        logic          ok;
        ok = 1'b1;
        d  = m_dir;
        case (b)
            4'b0001: d = sga_pkg::dir_up;
            4'b0010: d = sga_pkg::dir_down;
            4'b0100: d = sga_pkg::dir_left;
            4'b1000: d = sga_pkg::dir_right;
            default: ok = 1'b0;
        endcase
        if ((d == sga_pkg::dir_up && m_dir == sga_pkg::dir_down)
            || (d == sga_pkg::dir_down && m_dir == sga_pkg::dir_up)
            || (d == sga_pkg::dir_left && m_dir == sga_pkg::dir_right)
            || (d == sga_pkg::dir_right && m_dir == sga_pkg::dir_left)) begin
            ok = 1'b0;
        end
        if (ok) begin
            m_dir = d;
        end
    endtask

    task automatic model_step();
        int   row;
        int   col;
        int   nxt;
        logic wall;
        logic self_hit;
        logic eat;
        logic grow;
        row = m_seg[0] / sga_pkg::GRID_W;
        col = m_seg[0] % sga_pkg::GRID_W;
        case (m_dir)
            sga_pkg::dir_up: begin
                wall = (row == 0);
                nxt  = m_seg[0] - sga_pkg::GRID_W;
            end
            sga_pkg::dir_down: begin
                wall = (row == sga_pkg::GRID_W - 1);
                nxt  = m_seg[0] + sga_pkg::GRID_W;
            end
            sga_pkg::dir_left: begin
                wall = (col == 0);
                nxt  = m_seg[0] - 1;
            end
            default: begin
                wall = (col == sga_pkg::GRID_W - 1);
                nxt  = m_seg[0] + 1;
            end
        endcase
        eat      = !wall && (nxt == m_apple);
        grow     = eat && (m_len < sga_pkg::MAX_LEN);
        self_hit = 1'b0;
        // the tail leaves its cell unless the snake grows
        for (int i = 0; i < m_len; i++) begin
            if (!wall && m_seg[i] == nxt && !(i == m_len - 1 && !grow)) begin
                self_hit = 1'b1;
            end
        end
        if (wall || self_hit) begin
            m_over = 1'b1;
        end else begin
            for (int i = sga_pkg::MAX_LEN - 1; i > 0; i--) begin
                m_seg[i] = m_seg[i-1];
            end
            m_seg[0] = sga_pkg::pos_t'(nxt);
            if (grow) begin
                m_len++;
            end
            if (eat) begin
                m_score++;
                eats++;
                next_apple();
            end
        end
    endtask

    task automatic check_outputs();
        sga_pkg::frame_t exp_leds;
        exp_leds = model_frame();
        if (leds !== exp_leds) begin
            report_mismatch("leds", 64'(exp_leds), 64'(leds));
        end
        if (length !== m_len[3:0]) begin
            report_mismatch("length", 64'(m_len[3:0]), 64'(length));
        end
        if (score !== m_score[7:0]) begin
            report_mismatch("score", 64'(m_score[7:0]), 64'(score));
        end
        if (game_over !== m_over) begin
            report_mismatch("game_over", 64'(m_over), 64'(game_over));
        end
        if (busy !== 1'b0) begin
            report_mismatch("busy", 64'(0), 64'(busy));
        end
    endtask

    // mostly chase the apple, sometimes any pattern, sometimes nothing
    task automatic pick_buttons(output logic [3:0] b);
        logic [31:0] r;
        int          hr;
        int          hc;
        int          ar;
        int          ac;
        r  = $random(seed);
        hr = m_seg[0] / sga_pkg::GRID_W;
        hc = m_seg[0] % sga_pkg::GRID_W;
        ar = m_apple / sga_pkg::GRID_W;
        ac = m_apple % sga_pkg::GRID_W;
        b  = 4'b0000;
        if (r[2:0] < 3'd3) begin
            if ((r[3] || ar == hr) && ac != hc) begin
                b = (ac > hc) ? 4'b1000 : 4'b0100;
            end else if (ar != hr) begin
                b = (ar > hr) ? 4'b0010 : 4'b0001;
            end
        end else if (r[2:0] < 3'd5) begin
            b = r[7:4];
        end
    endtask

    task automatic issue_step(input logic [3:0] b);
        @(posedge clock);
        #2;
        step    = 1'b1;
        buttons = b;
        @(posedge clock);
        #2;
        step    = 1'b0;
        buttons = 4'b0000;
        steps++;
    endtask

    task automatic wait_frame(input string what);
        int n;
        n = 0;
        while (!frame_valid && !game_over && n < sga_pkg::CELLS + 80) begin
            @(negedge clock);
            n++;
        end
        if (m_over && game_over !== 1'b1) begin
            report_failure("game_over did not rise after a collision");
        end else if (!m_over && frame_valid !== 1'b1) begin
            report_failure(what);
        end
        check_outputs();
    endtask

    // steps while over are ignored, then restart and check the new game
    task automatic play_after_over();
        logic [3:0] b;
        repeat (3) @(negedge clock);
        repeat (2) begin
            pick_buttons(b);
            issue_step(b);
            repeat (10) begin
                @(negedge clock);
                if (frame_valid) begin
                    report_failure("frame_valid after game over");
                end
            end
            check_outputs();
        end
        @(posedge clock);
        #2;
        restart = 1'b1;
        @(posedge clock);
        #2;
        restart = 1'b0;
        model_new_game();
        wait_frame("no first frame after restart");
    endtask

    initial begin
        logic [3:0]  b;
        logic [31:0] r;
        seed       = 32'hfbb;
        mismatches = 0;
        failures   = 0;
        steps      = 0;
        eats       = 0;
        overs      = 0;
        rst        = 1'b1;
        restart    = 1'b0;
        step       = 1'b0;
        buttons    = 4'b0000;
        repeat (10) @(posedge clock);
        #2;
        rst = 1'b0;
        model_new_game();
        wait_frame("no first frame after reset");
        while (steps < 300) begin
            r = $random(seed);
            repeat (r[1:0]) @(negedge clock);
            while (busy) begin
                @(negedge clock);
            end
            pick_buttons(b);
            issue_step(b);
            model_buttons(b);
            model_step();
            @(negedge clock);
            if (busy !== 1'b1) begin
                report_failure("busy did not rise after an accepted step");
            end
            wait_frame("no frame_valid within CELLS+80 cycles of a step");
            if (m_over) begin
                overs++;
                play_after_over();
            end
        end
        $display("steps %0d, apples %0d, games over %0d, mismatches %0d, other errors %0d",
                 steps, eats, overs, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
design/sga_pkg.sv
design/sga_body_if.sv
design/sga_control.sv
design/sga_body_mem.sv
design/sga_apple_gen.sv
design/sga_renderer.sv
design/sga_top.sv
tests/sga_props.sv
tests/sga_tb.sv
